// File: src/sb_pkg.sv
package sb_pkg;

   // ******************************
   // Widths
   // ******************************
   localparam int SB_ADDR_WIDTH  = 32;                  // Store address bits.
   localparam int SB_DATA_WIDTH  = 32;                  // Store and bus data bits.
   localparam int SB_SEL_WIDTH   = 4;                   // One select per byte lane.
   localparam int SB_SIZE_WIDTH  = 2;                   // Store size code bits.
   localparam int SB_DEPTH_WIDTH = 3;                   // Log2 of buffer depth.

   // ******************************
   // Store size codes
   // ******************************
   localparam logic [SB_SIZE_WIDTH-1:0] SIZE_BYTE = 2'b00;   // 8-bit store.
   localparam logic [SB_SIZE_WIDTH-1:0] SIZE_HALF = 2'b01;   // 16-bit store.
   localparam logic [SB_SIZE_WIDTH-1:0] SIZE_WORD = 2'b10;   // 32-bit store.
   // Code 2'b11 is unused and rejected by the aligner.

   // ******************************
   // Buffered store entry
   // ******************************
   // One store as it will be presented on the data bus. The address has
   // its two low bits cleared, the data already sits on its byte lanes
   // and sel marks which lanes are written.
   typedef struct packed {
      logic [SB_ADDR_WIDTH-1:0] addr;                   // Word address.
      logic [SB_DATA_WIDTH-1:0] data;                   // Lane-aligned data.
      logic [SB_SEL_WIDTH-1:0]  sel;                    // Byte selects.
   } sb_entry_t;                                        // 68 bits total.

endpackage

// File: src/store_align.sv
`timescale 1ns/1ps

module store_align (
   input  logic                             store_i,       // Store strobe.
   input  logic [sb_pkg::SB_ADDR_WIDTH-1:0] store_addr_i,  // Byte address.
   input  logic [sb_pkg::SB_SIZE_WIDTH-1:0] store_size_i,  // Size code.
   input  logic [sb_pkg::SB_DATA_WIDTH-1:0] store_data_i,  // Value in low bits.
   output logic                             wr_en_o,       // Push to FIFO.
   output sb_pkg::sb_entry_t                wr_entry_o,    // Bus-ready entry.
   output logic                             err_o          // Misaligned store.
);

   import sb_pkg::*;

   logic                     misaligned;                   // Offset illegal for size.
   logic [SB_DATA_WIDTH-1:0] lane_data;                    // Data on byte lanes.
   logic [SB_SEL_WIDTH-1:0]  lane_sel;                     // Lanes written.

   // ******************************
   // Lane placement
   // ******************************
   always_comb begin
      misaligned = 1'b0;
      lane_data  = store_data_i;
      lane_sel   = '0;
      case (store_size_i)
         SIZE_BYTE: begin
            lane_data = {4{store_data_i[7:0]}};            // Byte on every lane.
            lane_sel  = 4'b0001 << store_addr_i[1:0];      // Pick one lane.
         end
         SIZE_HALF: begin
            lane_data  = {2{store_data_i[15:0]}};          // Half on both halves.
            lane_sel   = store_addr_i[1] ? 4'b1100 : 4'b0011;
            misaligned = store_addr_i[0];                  // Odd address.
         end
         SIZE_WORD: begin
            lane_sel   = 4'b1111;                          // Full word.
            misaligned = |store_addr_i[1:0];               // Any offset.
         end
         default: begin
            misaligned = 1'b1;                             // Unused code, reject.
         end
      endcase
   end

   // Strobe goes to exactly one of the two outputs.
   assign wr_en_o = store_i & ~misaligned;                 // Accepted store.
   assign err_o   = store_i & misaligned;                  // Same-cycle error pulse.

   assign wr_entry_o.addr = {store_addr_i[SB_ADDR_WIDTH-1:2], 2'b00}; // Word address.
   assign wr_entry_o.data = lane_data;
   assign wr_entry_o.sel  = lane_sel;

endmodule

// File: src/sb_fifo.sv
`timescale 1ns/1ps

module sb_fifo #(
   parameter int  DEPTH_WIDTH = sb_pkg::SB_DEPTH_WIDTH,    // Log2 of entries.
   parameter type payload_t   = logic                      // Stored item type.
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     wr_en_i,                               // Push.
   input  payload_t wr_data_i,                             // Item to push.
   input  logic     rd_en_i,                               // Pop.
   output payload_t rd_data_o,                             // Valid cycle after pop.
   output logic     full_o,
   output logic     empty_o
);

   localparam int DEPTH = 1 << DEPTH_WIDTH;                // Number of entries.

   // ******************************
   // Pointers
   // ******************************
   // Top bit of each pointer is a wrap flag. Same index with same wrap
   // means empty, same index with opposite wrap means full.
   logic [DEPTH_WIDTH:0]   wr_ptr;                         // Write pointer plus wrap.
   logic [DEPTH_WIDTH:0]   rd_ptr;                         // Read pointer plus wrap.
   logic                   idx_equal;                      // Low bits match.
   logic                   wrap_equal;                     // Wrap bits match.

   assign idx_equal  = (wr_ptr[DEPTH_WIDTH-1:0] == rd_ptr[DEPTH_WIDTH-1:0]);
   assign wrap_equal = (wr_ptr[DEPTH_WIDTH] == rd_ptr[DEPTH_WIDTH]);

   assign full_o  = idx_equal & ~wrap_equal;               // Writer lapped reader.
   assign empty_o = idx_equal & wrap_equal;                // Nothing stored.

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en_i) begin
            wr_ptr <= wr_ptr + 1'b1;                       // Advance on push.
         end
         if (rd_en_i) begin
            rd_ptr <= rd_ptr + 1'b1;                       // Advance on pop.
         end
      end
   end

   // ******************************
   // Storage
   // ******************************
   payload_t               mem [DEPTH];                    // Entry array.
   logic [DEPTH_WIDTH-1:0] rd_addr_q;                      // Registered read index.

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_ptr[DEPTH_WIDTH-1:0]] <= wr_data_i;        // Write at tail.
      end
      rd_addr_q <= rd_ptr[DEPTH_WIDTH-1:0];                // Head before any pop.
   end

   // A pop on edge N latches the old head index, so the popped entry
   // is on rd_data_o for the whole next cycle.
   assign rd_data_o = mem[rd_addr_q];

endmodule

// File: src/store_buffer_drain.sv
`timescale 1ns/1ps

module store_buffer_drain (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             fifo_empty_i,  // Buffer has nothing.
   output logic                             fifo_rd_en_o,  // Pop strobe.
   input  sb_pkg::sb_entry_t                fifo_data_i,   // Valid after pop.
   output logic                             bus_req_o,     // Write request.
   output logic [sb_pkg::SB_ADDR_WIDTH-1:0] bus_addr_o,
   output logic [sb_pkg::SB_DATA_WIDTH-1:0] bus_data_o,
   output logic [sb_pkg::SB_SEL_WIDTH-1:0]  bus_sel_o,
   input  logic                             bus_ack_i      // Write done.
);

   // ******************************
   // Drain FSM
   // ******************************
   typedef enum logic [1:0] {
      ST_IDLE,                                             // Waiting for an entry.
      ST_FETCH,                                            // Popped data on FIFO output.
      ST_REQ                                               // Request on the bus.
   } state_t;

   state_t state_q;
   state_t state_d;

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (!fifo_empty_i) begin
               state_d = ST_FETCH;                         // Pop issued this cycle.
            end
         end
         ST_FETCH: begin
            state_d = ST_REQ;                              // Fields captured now.
         end
         ST_REQ: begin
            if (bus_ack_i) begin
               state_d = ST_IDLE;                          // Drop request next edge.
            end
         end
         default: begin
            state_d = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Only pop from idle, so one store is in flight at a time.
   assign fifo_rd_en_o = (state_q == ST_IDLE) & ~fifo_empty_i;
   assign bus_req_o    = (state_q == ST_REQ);              // Straight from state reg.

   // ******************************
   // Bus field registers
   // ******************************
   always_ff @(posedge clk) begin
      if (state_q == ST_FETCH) begin
         bus_addr_o <= fifo_data_i.addr;                   // Held until ack.
         bus_data_o <= fifo_data_i.data;
         bus_sel_o  <= fifo_data_i.sel;
      end
   end

endmodule

// File: src/store_buffer_top.sv
`timescale 1ns/1ps

module store_buffer_top (
   input  logic                             clk,
   input  logic                             rst,
   // Store side, from the core.
   input  logic                             store_i,
   input  logic [sb_pkg::SB_ADDR_WIDTH-1:0] store_addr_i,
   input  logic [sb_pkg::SB_SIZE_WIDTH-1:0] store_size_i,
   input  logic [sb_pkg::SB_DATA_WIDTH-1:0] store_data_i,
   output logic                             store_err_o,   // Misaligned store.
   output logic                             full_o,        // Core must hold off.
   output logic                             empty_o,
   // Data bus write side.
   output logic                             bus_req_o,
   output logic [sb_pkg::SB_ADDR_WIDTH-1:0] bus_addr_o,
   output logic [sb_pkg::SB_DATA_WIDTH-1:0] bus_data_o,
   output logic [sb_pkg::SB_SEL_WIDTH-1:0]  bus_sel_o,
   input  logic                             bus_ack_i
);

   import sb_pkg::*;

   logic      align_wr_en;                                 // Accepted store.
   sb_entry_t align_entry;                                 // Entry to buffer.
   logic      fifo_rd_en;                                  // Pop from drain.
   sb_entry_t fifo_rd_data;                                // Head entry.

   // ******************************
   // Aligner
   // ******************************
   store_align u_align (
      .store_i      (store_i),
      .store_addr_i (store_addr_i),
      .store_size_i (store_size_i),
      .store_data_i (store_data_i),
      .wr_en_o      (align_wr_en),
      .wr_entry_o   (align_entry),
      .err_o        (store_err_o)
   );

   // ******************************
   // Buffer and drain
   // ******************************
   sb_fifo #(
      .DEPTH_WIDTH (SB_DEPTH_WIDTH),
      .payload_t   (sb_entry_t)
   ) u_fifo (
      .clk       (clk),
      .rst       (rst),
      .wr_en_i   (align_wr_en),
      .wr_data_i (align_entry),
      .rd_en_i   (fifo_rd_en),
      .rd_data_o (fifo_rd_data),
      .full_o    (full_o),
      .empty_o   (empty_o)                                 // Also feeds the drain.
   );

   store_buffer_drain u_drain (
      .clk          (clk),
      .rst          (rst),
      .fifo_empty_i (empty_o),
      .fifo_rd_en_o (fifo_rd_en),
      .fifo_data_i  (fifo_rd_data),
      .bus_req_o    (bus_req_o),
      .bus_addr_o   (bus_addr_o),
      .bus_data_o   (bus_data_o),
      .bus_sel_o    (bus_sel_o),
      .bus_ack_i    (bus_ack_i)
   );

endmodule

// File: tb/store_buffer_sva.sv
`timescale 1ns/1ps

module store_buffer_sva (
   input logic                             clk,
   input logic                             rst,
   input logic                             store_err_o,
   input logic                             full_o,
   input logic                             empty_o,
   input logic                             bus_req_o,
   input logic [sb_pkg::SB_ADDR_WIDTH-1:0] bus_addr_o,
   input logic [sb_pkg::SB_DATA_WIDTH-1:0] bus_data_o,
   input logic [sb_pkg::SB_SEL_WIDTH-1:0]  bus_sel_o,
   input logic                             bus_ack_i
);

   logic fail_seen = 1'b0;                                 // Sticky, watched by the testbench.

   // ******************************
   // Bus write protocol
   // ******************************
   req_hold: assert property (@(posedge clk) disable iff (rst)
      bus_req_o && !bus_ack_i |=> bus_req_o && $stable(bus_addr_o)
         && $stable(bus_data_o) && $stable(bus_sel_o))
      else begin fail_seen = 1'b1; $error("Request or bus fields changed before ack."); end

   req_drop: assert property (@(posedge clk) disable iff (rst)
      bus_req_o && bus_ack_i |=> !bus_req_o)               // Falls on edge after ack.
      else begin fail_seen = 1'b1; $error("Request still high after ack."); end

   // ******************************
   // Buffer status
   // ******************************
   full_not_empty: assert property (@(posedge clk) disable iff (rst)
      !(full_o && empty_o))
      else begin fail_seen = 1'b1; $error("Buffer full and empty at once."); end

   err_not_full: assert property (@(posedge clk) disable iff (rst)
      !(store_err_o && full_o))                            // No store while full.
      else begin fail_seen = 1'b1; $error("Store error while buffer full."); end

   // Reset values.
   reset_out: assert property (@(posedge clk)
      rst |=> !bus_req_o && !full_o && empty_o)
      else begin fail_seen = 1'b1; $error("Wrong outputs after reset."); end

   reset_err: assert property (@(posedge clk)
      rst |-> !store_err_o)
      else begin fail_seen = 1'b1; $error("Store error during reset."); end

endmodule

bind store_buffer_top store_buffer_sva u_sva (
   .clk         (clk),
   .rst         (rst),
   .store_err_o (store_err_o),
   .full_o      (full_o),
   .empty_o     (empty_o),
   .bus_req_o   (bus_req_o),
   .bus_addr_o  (bus_addr_o),
   .bus_data_o  (bus_data_o),
   .bus_sel_o   (bus_sel_o),
   .bus_ack_i   (bus_ack_i)
);

// File: tb/store_buffer_tb.sv
`timescale 1ns/1ps

module store_buffer_tb;

   import sb_pkg::*;

   localparam int RANDOM_STORES = 300;                     // Length of the random run.
   localparam int FIFO_DEPTH    = 1 << SB_DEPTH_WIDTH;

   logic                     clk;
   logic                     rst;
   logic                     store_i;
   logic [SB_ADDR_WIDTH-1:0] store_addr_i;
   logic [SB_SIZE_WIDTH-1:0] store_size_i;
   logic [SB_DATA_WIDTH-1:0] store_data_i;
   logic                     store_err_o;
   logic                     full_o;
   logic                     empty_o;
   logic                     bus_req_o;
   logic [SB_ADDR_WIDTH-1:0] bus_addr_o;
   logic [SB_DATA_WIDTH-1:0] bus_data_o;
   logic [SB_SEL_WIDTH-1:0]  bus_sel_o;
   logic                     bus_ack_i;

   sb_entry_t exp_q[$];                                    // Accepted stores awaiting the bus.
   int        stores_issued = 0;                           // Includes rejected ones.
   bit        hold_ack      = 1'b0;                        // Withhold acks.

   store_buffer_top u_store_buffer_top (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;                               // 4 ns period.
   end

   // ******************************
   // Checking helpers
   // ******************************
   task automatic report_failure(input string what);
      $display("%s", what);
      $display("TB FAILED");
      $fatal(1, "Stopping at the first failure.");
   endtask

   task automatic check_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else report_failure($sformatf(
         "Error: time %0d ns, %s is 0x%0h, expected 0x%0h", $time, name, got, exp));
   endtask

   // Lane rules, worked out lane by lane.
   function automatic sb_entry_t predict_entry(input logic [31:0] addr,
                                               input logic [1:0] size,
                                               input logic [31:0] value);
      sb_entry_t e;
      e.addr = addr & 32'hffff_fffc;                       // Word address.
      e.data = '0;
      e.sel  = '0;
      for (int lane = 0; lane < 4; lane++) begin
         if (size == SIZE_BYTE) begin
            e.data[8*lane +: 8] = value[7:0];              // Same byte on each lane.
            e.sel[lane]         = (addr[1:0] == lane[1:0]);
         end else if (size == SIZE_HALF) begin
            e.data[8*lane +: 8] = value[8*(lane%2) +: 8];  // Half repeated.
            e.sel[lane]         = (addr[1] == lane[1]);
         end else begin
            e.data[8*lane +: 8] = value[8*lane +: 8];
            e.sel[lane]         = 1'b1;
         end
      end
      return e;
   endfunction

   function automatic bit is_misaligned(input logic [31:0] addr, input logic [1:0] size);
      return (size == SIZE_HALF && addr[0]) || (size == SIZE_WORD && addr[1:0] != 2'b00);
   endfunction

   // ******************************
   // Stimulus helpers
   // ******************************
   // Called 1 ns after an edge, returns 1 ns after the next one.
   task automatic issue_store(input logic [31:0] addr, input logic [1:0] size,
                              input logic [31:0] value);
      bit bad;
      bad          = is_misaligned(addr, size);
      store_i      = 1'b1;
      store_addr_i = addr;
      store_size_i = size;
      store_data_i = value;
      stores_issued++;
      if (!bad) begin
         exp_q.push_back(predict_entry(addr, size, value));
      end
      @(negedge clk);
      check_equal("store_err_o", 32'(store_err_o), 32'(bad)); // Same-cycle pulse.
      @(posedge clk);
      #1;
      store_i = 1'b0;
   endtask

   // Waits until every accepted store was acked, then the DUT must be idle.
   task automatic wait_drained();
      while (exp_q.size() != 0) begin
         @(posedge clk);
         #1;
      end
      check_equal("empty_o", 32'(empty_o), 32'd1);         // Nothing left buffered.
      check_equal("bus_req_o", 32'(bus_req_o), 32'd0);     // Request dropped after last ack.
   endtask

   // Bus responder, random 0 to 5 cycle ack delay.
   initial begin : responder
      int delay_left;
      bus_ack_i  = 1'b0;
      delay_left = -1;
      forever begin
         @(posedge clk);
         #1;
         bus_ack_i = 1'b0;                                 // One-cycle pulse.
         if (!bus_req_o) begin
            delay_left = -1;
         end else if (!hold_ack) begin
            if (delay_left < 0) begin
               delay_left = int'($urandom_range(5, 0));    // New request.
            end
            if (delay_left == 0) begin
               bus_ack_i = 1'b1;
            end else begin
               delay_left--;
            end
         end
      end
   end

   // ******************************
   // Scoreboard and monitors
   // ******************************
   always @(negedge clk) begin : scoreboard
      sb_entry_t exp_e;
      if (!rst && bus_req_o && bus_ack_i) begin
         assert (exp_q.size() != 0)
            else report_failure("Bus write acknowledged with no store pending.");
         exp_e = exp_q.pop_front();
         check_equal("bus_addr_o", bus_addr_o, exp_e.addr);
         check_equal("bus_data_o", bus_data_o, exp_e.data);
         check_equal("bus_sel_o", 32'(bus_sel_o), 32'(exp_e.sel));
      end
   end

   always @(negedge clk) begin
      assert (!u_store_buffer_top.u_sva.fail_seen)
         else report_failure("A bound bus or status assertion failed.");
   end

   initial begin : watchdog
      int cycle_cnt;
      cycle_cnt = 0;
      while (cycle_cnt <= 40 * stores_issued + 200) begin  // Limit grows with stores.
         @(posedge clk);
         cycle_cnt++;
      end
      report_failure("Timeout, the run did not finish in time.");
   end

   // ******************************
   // Test sequence
   // ******************************
   initial begin : stimulus
      logic [31:0] addr;
      logic [1:0]  size;
      int unsigned gap;
      void'($urandom(32'h37785c51));
      rst          = 1'b1;
      store_i      = 1'b0;
      store_addr_i = '0;
      store_size_i = SIZE_BYTE;
      store_data_i = '0;
      repeat (16) @(posedge clk);
      #1;
      rst = 1'b0;
      @(negedge clk);
      check_equal("empty_o", 32'(empty_o), 32'd1);
      check_equal("bus_req_o", 32'(bus_req_o), 32'd0);
      check_equal("full_o", 32'(full_o), 32'd0);
      check_equal("store_err_o", 32'(store_err_o), 32'd0);
      @(posedge clk);
      #1;

      // Lane placement for each size.
      issue_store(32'h0000_1000, SIZE_WORD, 32'hdead_beef);
      issue_store(32'h0000_1002, SIZE_HALF, 32'h0000_a55a);
      issue_store(32'h0000_1000, SIZE_HALF, 32'h1234_5678);
      for (int off = 0; off < 4; off++) begin
         issue_store(32'h0000_2000 + off, SIZE_BYTE, 32'h0000_0c10 + off);
      end
      wait_drained();

      // Misaligned stores mixed with good ones.
      issue_store(32'h0000_3001, SIZE_HALF, 32'h0000_1111);
      issue_store(32'h0000_3004, SIZE_WORD, 32'h0bad_f00d);
      issue_store(32'h0000_3002, SIZE_WORD, 32'h2222_2222);
      issue_store(32'h0000_3003, SIZE_WORD, 32'h3333_3333);
      issue_store(32'h0000_3006, SIZE_HALF, 32'h0000_7e57);
      wait_drained();

      // Fill with acks withheld.
      hold_ack = 1'b1;
      issue_store(32'h0000_4000, SIZE_WORD, 32'h4000_0000);
      while (!bus_req_o) begin
         @(posedge clk);
         #1;
      end
      for (int i = 1; i <= FIFO_DEPTH; i++) begin
         check_equal("full_o", 32'(full_o), 32'd0);
         issue_store(32'h0000_4000 + 4 * i, SIZE_WORD, 32'h4000_0000 + i);
      end
      check_equal("full_o", 32'(full_o), 32'd1);
      check_equal("bus_req_o", 32'(bus_req_o), 32'd1);
      repeat (3) @(posedge clk);
      #1;
      hold_ack = 1'b0;
      wait_drained();

      // Random run, room tracked from the expected count.
      for (int n = 0; n < RANDOM_STORES; n++) begin
         gap = $urandom_range(2, 0);
         repeat (gap) begin
            @(posedge clk);
            #1;
         end
         while (exp_q.size() >= FIFO_DEPTH) begin
            @(posedge clk);
            #1;
         end
         size = 2'($urandom_range(2, 0));
         addr = $urandom;
         if (size != SIZE_BYTE && $urandom_range(3, 0) != 0) begin
            addr[1:0] = 2'b00;                             // Mostly aligned.
         end
         issue_store(addr, size, $urandom);
      end
      wait_drained();

      // An assertion may have fired on the last edge, after the last monitor look.
      if (u_store_buffer_top.u_sva.fail_seen) begin
         report_failure("A bound bus or status assertion failed.");
      end else begin
         $display("TB PASSED");
         $finish;
      end
   end

endmodule

// File: tb.f
src/sb_pkg.sv
src/store_align.sv
src/sb_fifo.sv
src/store_buffer_drain.sv
src/store_buffer_top.sv
tb/store_buffer_sva.sv
tb/store_buffer_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the store buffer testbench with Verilator.
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module store_buffer_tb -o store_buffer_sim

# A failing run exits non-zero, the log scan below gives the verdict.
./obj_dir/store_buffer_sim +verilator+error+limit+100 > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
   echo "Simulation failed, see $LOG"
   exit 1
fi
if ! grep -q "TB PASSED" "$LOG"; then
   echo "Simulation ended without a result, see $LOG"
   exit 1
fi
echo "Simulation passed"
